//--- list.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/exec_if.sv
rtl/reg_file.sv
rtl/alu_exec.sv
rtl/writeback.sv
rtl/cpu_backend.sv
bench/backend_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module backend_tb -f list.f -o Vbackend_tb

./obj_dir/Vbackend_tb 2>&1 | tee sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

//--- bench/backend_tb.sv
`default_nettype none
`include "cpu_consts.svh"

module backend_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_pkg::*;

  typedef struct packed {
    logic        valid;
    logic        is_pc;       // pc event, else register write
    logic [3:0]  addr;
    logic [31:0] data;
    logic [31:0] acc_edge;
    logic [31:0] acc_stalls;
  } exp_item_t;

  logic             clk_i = 1'b0;
  logic             rst_i;
  logic             instr_valid_i;
  logic [63:0]      ir_i;
  logic [`XLEN-1:0] pc_i;
  logic             stall_i;
  logic             pc_set_o;
  logic [`XLEN-1:0] pc_o;
  logic             wb_we_o;
  logic [3:0]       wb_addr_o;
  logic [`XLEN-1:0] wb_data_o;

  int               seed = 15;
  logic [31:0]      m_regs [`NREGS];
  logic [31:0]      m_cmp_b;    // operands of the last compare
  logic [31:0]      m_cmp_c;
  exp_item_t        exp_q [$];
  logic [31:0]      edge_cnt;
  logic [31:0]      stall_cnt;
  logic [31:0]      cur_pc;
  logic [3:0]       last_ra;
  int               n_events;

  cpu_backend dut (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .ir_i          (ir_i),
    .pc_i          (pc_i),
    .stall_i       (stall_i),
    .pc_set_o      (pc_set_o),
    .pc_o          (pc_o),
    .wb_we_o       (wb_we_o),
    .wb_addr_o     (wb_addr_o),
    .wb_data_o     (wb_data_o)
  );

  always #4 clk_i = ~clk_i;

  task automatic fail_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_run();
    end
  endtask

  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [63:0] make_ir(input logic [3:0] typ, input logic [3:0] op,
                                          input logic [3:0] ra, input logic [3:0] rb,
                                          input logic [3:0] rc, input logic [31:0] imm);
    logic [31:0] lo;
    lo = '0;
    lo[`TYPE_LSB +: 4] = typ;
    lo[`OP_LSB +: 4]   = op;
    lo[`RA_LSB +: 4]   = ra;
    lo[`RB_LSB +: 4]   = rb;
    lo[`RC_LSB +: 4]   = rc;
    return {imm, lo};
  endfunction

  // half the sources hit the last written register
  function automatic logic [3:0] pick_src();
    if (rnd(2) == 0)
      return last_ra;
    return 4'(rnd(`NREGS));
  endfunction

  function automatic logic [63:0] random_instr(input int unsigned kind);
    logic [3:0]  ra;
    logic [63:0] ir;
    ra = 4'(rnd(`NREGS));
    case (kind)
      0: ir = make_ir(T_ALU, 4'(rnd(7)), ra, pick_src(), pick_src(), 32'h0);
      1: ir = make_ir(T_LDI, 4'h0, ra, 4'h0, 4'h0, $random(seed));
      2: ir = make_ir(T_CMP, 4'h0, 4'h0, pick_src(), pick_src(), 32'h0);
      3: ir = make_ir(T_BRANCH, 4'(rnd(11)), 4'h0, 4'h0, 4'h0, $random(seed));
      4: ir = make_ir(T_JUMP, 4'h0, 4'h0, 4'h0, 4'h0, $random(seed));
      default: ir = make_ir(T_NOP, 4'h0, 4'h0, 4'h0, 4'h0, 32'h0);
    endcase
    if (kind < 2)
      last_ra = ra;
    return ir;
  endfunction

  function automatic exp_item_t ref_exec(input logic [63:0] ir, input logic [31:0] pc);
    exp_item_t   it;
    logic [3:0]  typ;
    logic [3:0]  op;
    logic [3:0]  ra;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] imm;
    it  = '0;
    typ = ir[`TYPE_LSB +: 4];
    op  = ir[`OP_LSB +: 4];
    ra  = ir[`RA_LSB +: 4];
    b   = m_regs[ir[`RB_LSB +: 4]];
    c   = m_regs[ir[`RC_LSB +: 4]];
    imm = ir[63:32];
    case (typ)
      T_ALU:
      begin
        case (op)
          ALU_ADD: it.data = b + c;
          ALU_SUB: it.data = b - c;
          ALU_AND: it.data = b & c;
          ALU_OR:  it.data = b | c;
          ALU_XOR: it.data = b ^ c;
          ALU_SHL: it.data = b << c[4:0];
          default: it.data = b >> c[4:0];
        endcase
        it.valid = 1'b1;
      end
      T_LDI:
      begin
        it.data  = imm;
        it.valid = 1'b1;
      end
      T_CMP:
      begin
        m_cmp_b = b;
        m_cmp_c = c;
      end
      T_BRANCH:
      begin
        case (op)
          BR_BRA:  it.valid = 1'b1;
          BR_BEQ:  it.valid = (m_cmp_b == m_cmp_c);
          BR_BNE:  it.valid = (m_cmp_b != m_cmp_c);
          BR_BGTU: it.valid = (m_cmp_b > m_cmp_c);
          BR_BGT:  it.valid = ($signed(m_cmp_b) > $signed(m_cmp_c));
          BR_BGE:  it.valid = ($signed(m_cmp_b) >= $signed(m_cmp_c));
          BR_BLE:  it.valid = ($signed(m_cmp_b) <= $signed(m_cmp_c));
          BR_BLT:  it.valid = ($signed(m_cmp_b) < $signed(m_cmp_c));
          BR_BGEU: it.valid = (m_cmp_b >= m_cmp_c);
          BR_BLTU: it.valid = (m_cmp_b < m_cmp_c);
          BR_BLEU: it.valid = (m_cmp_b <= m_cmp_c);
          default: it.valid = 1'b0;
        endcase
        it.is_pc = 1'b1;
        it.data  = pc + imm;
      end
      T_JUMP:
      begin
        it.valid = 1'b1;
        it.is_pc = 1'b1;
        it.data  = imm;
      end
      default: it.valid = 1'b0;  // bubble
    endcase
    if (it.valid && !it.is_pc)
    begin
      it.addr    = ra;
      m_regs[ra] = it.data;
    end
    return it;
  endfunction

  // optional gap and stall cycles, then held until the accepting edge
  task automatic send_instr(input logic [63:0] ir, input bit stalls);
    int unsigned n_hold;
    n_hold = 0;
    if (stalls && rnd(4) == 0)
    begin
      @(posedge clk_i);
      instr_valid_i <= 1'b0;
      stall_i       <= (rnd(2) == 0);
    end
    if (stalls && rnd(3) == 0)
      n_hold = 1 + rnd(3);
    for (int unsigned i = 0; i < n_hold; i++)
    begin
      @(posedge clk_i);
      instr_valid_i <= (rnd(2) == 0);
      stall_i       <= 1'b1;
      ir_i          <= ir;
      pc_i          <= cur_pc;
    end
    @(posedge clk_i);
    instr_valid_i <= 1'b1;
    stall_i       <= 1'b0;
    ir_i          <= ir;
    pc_i          <= cur_pc;
    cur_pc = cur_pc + 8;
  endtask

  task automatic take_event(input bit is_pc);
    exp_item_t it;
    if (exp_q.size() == 0)
    begin
      $display("output event at %0t with no instruction pending", $time);
      fail_run();
    end
    else
    begin
      it = exp_q.pop_front();
      check_val("event kind (1 is pc_set_o)", 32'(is_pc), 32'(it.is_pc));
      if (is_pc)
        check_val("pc_o", pc_o, it.data);
      else
      begin
        check_val("wb_addr_o", 32'(wb_addr_o), 32'(it.addr));
        check_val("wb_data_o", wb_data_o, it.data);
        check_val("write latency", edge_cnt + 1 - it.acc_edge,
                  2 + stall_cnt - it.acc_stalls);
      end
      n_events++;
    end
  endtask

  // accepted instructions into the model, in order
  always @(posedge clk_i)
  begin
    exp_item_t it;
    if (!rst_i)
    begin
      edge_cnt = edge_cnt + 1;
      if (stall_i)
        stall_cnt = stall_cnt + 1;
      if (instr_valid_i && !stall_i)
      begin
        it            = ref_exec(ir_i, pc_i);
        it.acc_edge   = edge_cnt;
        it.acc_stalls = stall_cnt;
        if (it.valid)
          exp_q.push_back(it);
      end
    end
  end

  always @(negedge clk_i)
  begin
    if (!rst_i)
    begin
      if (stall_i && pc_set_o)
      begin
        $display("pc_set_o went high while stall_i was high at %0t", $time);
        fail_run();
      end
      if (wb_we_o)
        take_event(1'b0);
      if (pc_set_o)
        take_event(1'b1);  // older write goes first
    end
  end

  initial
  begin
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [31:0] val;
    int          wait_cnt;
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    ir_i          = '0;
    pc_i          = '0;
    stall_i       = 1'b0;
    edge_cnt      = 0;
    stall_cnt     = 0;
    cur_pc        = 32'h0000_1000;
    last_ra       = 4'h0;
    n_events      = 0;
    m_cmp_b       = 32'd1;  // gives all-zero codes like reset
    m_cmp_c       = 32'd0;
    for (int i = 0; i < `NREGS; i++)
      m_regs[i] = '0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;

    for (int i = 0; i < 8; i++)
    begin
      @(negedge clk_i);
      check_val("wb_we_o", 32'(wb_we_o), 32'h0);
      check_val("pc_set_o", 32'(pc_set_o), 32'h0);
    end

    for (int r = 0; r < `NREGS; r++)
      send_instr(make_ir(T_LDI, 4'h0, 4'(r), 4'h0, 4'h0, $random(seed)), 1'b0);
    for (int i = 0; i < 60; i++)
      send_instr(random_instr(rnd(2)), 1'b0);

    for (int k = 0; k < 12; k++)
    begin
      ra  = 4'(rnd(`NREGS));
      rb  = 4'(rnd(`NREGS));
      val = $random(seed);
      send_instr(make_ir(T_LDI, 4'h0, ra, 4'h0, 4'h0, val), 1'b0);
      send_instr(make_ir(T_LDI, 4'h0, rb, 4'h0, 4'h0,
                         (rnd(4) == 0) ? val : $random(seed)), 1'b0);
      send_instr(make_ir(T_CMP, 4'h0, 4'h0, ra, rb, 32'h0), 1'b0);
      for (int op = 0; op < 11; op++)
        send_instr(make_ir(T_BRANCH, 4'(op), 4'h0, 4'h0, 4'h0, $random(seed)), 1'b0);
      send_instr(make_ir(T_JUMP, 4'h0, 4'h0, 4'h0, 4'h0, $random(seed)), 1'b0);
    end

    for (int i = 0; i < 300; i++)
      send_instr(random_instr(rnd(6)), 1'b1);

    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    stall_i       <= 1'b0;
    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < 20)
    begin
      @(posedge clk_i);
      wait_cnt++;
    end
    for (int i = 0; i < 4; i++)
      @(posedge clk_i);  // catch late extra events

    if (exp_q.size() == 0)
    begin
      $display("%0d output events matched", n_events);
      $display("Done: no errors");
      $finish;
    end
    else
    begin
      $display("timeout with %0d expected events never seen", exp_q.size());
      fail_run();
    end
  end

endmodule

`default_nettype wire

//--- rtl/cpu_backend.sv
`default_nettype none
`include "cpu_consts.svh"

module cpu_backend (
  input  wire               clk_i,
  input  wire               rst_i,
  input  wire               instr_valid_i,
  input  wire [63:0]        ir_i,
  input  wire [`XLEN-1:0]   pc_i,
  input  wire               stall_i,
  output logic              pc_set_o,
  output logic [`XLEN-1:0]  pc_o,
  output logic              wb_we_o,
  output logic [3:0]        wb_addr_o,
  output logic [`XLEN-1:0]  wb_data_o
);

  logic [3:0]       rb_addr;
  logic [3:0]       rc_addr;
  logic [`XLEN-1:0] rb_data;
  logic [`XLEN-1:0] rc_data;

  exec_if ex_bus ();

  reg_file u_reg_file (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .ra_addr_i (rb_addr),
    .rb_addr_i (rc_addr),
    .ra_data_o (rb_data),
    .rb_data_o (rc_data),
    .we_i      (wb_we_o),    // write-back drives the write port
    .wr_addr_i (wb_addr_o),
    .wr_data_i (wb_data_o)
  );

  alu_exec u_alu_exec (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .ir_i          (ir_i),
    .pc_i          (pc_i),
    .stall_i       (stall_i),
    .rb_addr_o     (rb_addr),
    .rc_addr_o     (rc_addr),
    .rb_data_i     (rb_data),
    .rc_data_i     (rc_data),
    .ex            (ex_bus.src)
  );

  writeback u_writeback (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .stall_i          (stall_i),
    .ex               (ex_bus.dst),
    .pc_set_o         (pc_set_o),
    .pc_o             (pc_o),
    .result_o         (wb_data_o),
    .reg_write_o      (wb_we_o),
    .reg_write_addr_o (wb_addr_o)
  );

endmodule

`default_nettype wire

//--- rtl/writeback.sv
`default_nettype none
`include "cpu_consts.svh"

module writeback (
  input  wire               clk_i,
  input  wire               rst_i,
  input  wire               stall_i,
  exec_if.dst               ex,
  output logic              pc_set_o,
  output logic [`XLEN-1:0]  pc_o,
  output logic [`XLEN-1:0]  result_o,
  output logic              reg_write_o,
  output logic [3:0]        reg_write_addr_o
);
  import cpu_pkg::*;

  ir_type_e         ir_type;
  br_op_e           br_op;
  logic             br_cond;
  logic             taken;
  logic [`XLEN-1:0] pc_q;

  assign ir_type = ir_type_e'(ex.ir[`TYPE_LSB +: 4]);
  assign br_op   = br_op_e'(ex.ir[`OP_LSB +: 4]);

  always_comb
  begin
    case (br_op)
      BR_BRA:  br_cond = 1'b1;
      BR_BEQ:  br_cond = ex.ccr.eq;
      BR_BNE:  br_cond = !ex.ccr.eq;
      BR_BGTU: br_cond = !(ex.ccr.ltu || ex.ccr.eq);
      BR_BGT:  br_cond = !(ex.ccr.lt || ex.ccr.eq);
      BR_BGE:  br_cond = !ex.ccr.lt;
      BR_BLE:  br_cond = ex.ccr.lt || ex.ccr.eq;
      BR_BLT:  br_cond = ex.ccr.lt;
      BR_BGEU: br_cond = !ex.ccr.ltu;
      BR_BLTU: br_cond = ex.ccr.ltu;
      BR_BLEU: br_cond = ex.ccr.ltu || ex.ccr.eq;
      default: br_cond = 1'b0;  // reserved opcodes fall through
    endcase
  end

  assign taken = (ir_type == T_JUMP) || ((ir_type == T_BRANCH) && br_cond);

  // next pc goes out the same cycle
  always_comb
  begin
    pc_set_o = 1'b0;
    pc_o     = ex.pc;
    if (stall_i)
    begin
      pc_o = pc_q;
    end
    else if (taken)
    begin
      pc_set_o = 1'b1;
      pc_o     = ex.result;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      pc_q        <= '0;
      reg_write_o <= 1'b0;
    end
    else
    begin
      pc_q        <= pc_o;
      reg_write_o <= ex.reg_write && !stall_i;  // held instr writes once
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      result_o         <= ex.result;
      reg_write_addr_o <= ex.ir[`RA_LSB +: 4];
    end
  end

endmodule

`default_nettype wire

//--- rtl/alu_exec.sv
`default_nettype none
`include "cpu_consts.svh"

module alu_exec (
  input  wire               clk_i,
  input  wire               rst_i,
  input  wire               instr_valid_i,
  input  wire [63:0]        ir_i,
  input  wire [`XLEN-1:0]   pc_i,
  input  wire               stall_i,
  output logic [3:0]        rb_addr_o,
  output logic [3:0]        rc_addr_o,
  input  wire [`XLEN-1:0]   rb_data_i,
  input  wire [`XLEN-1:0]   rc_data_i,
  exec_if.src               ex
);
  import cpu_pkg::*;

  localparam logic [31:0] NOP_IR = 32'(T_NOP) << `TYPE_LSB;

  logic             accept;
  ir_type_e         ir_type;
  alu_op_e          alu_op;
  logic [`XLEN-1:0] imm;
  logic [3:0]       ex_ra;
  logic             fwd_b;
  logic             fwd_c;
  logic [`XLEN-1:0] opnd_b;
  logic [`XLEN-1:0] opnd_c;
  logic [`XLEN-1:0] alu_out;
  logic [`XLEN-1:0] result_next;
  ccr_t             ccr_next;

  assign accept  = instr_valid_i && !stall_i;
  assign ir_type = ir_type_e'(ir_i[`TYPE_LSB +: 4]);
  assign alu_op  = alu_op_e'(ir_i[`OP_LSB +: 4]);
  assign imm     = ir_i[63:32];

  assign rb_addr_o = ir_i[`RB_LSB +: 4];
  assign rc_addr_o = ir_i[`RC_LSB +: 4];

  // pending result not yet in the register file
  assign ex_ra  = ex.ir[`RA_LSB +: 4];
  assign fwd_b  = ex.reg_write && (ex_ra == rb_addr_o);
  assign fwd_c  = ex.reg_write && (ex_ra == rc_addr_o);
  assign opnd_b = fwd_b ? ex.result : rb_data_i;
  assign opnd_c = fwd_c ? ex.result : rc_data_i;

  always_comb
  begin
    case (alu_op)
      ALU_ADD: alu_out = opnd_b + opnd_c;
      ALU_SUB: alu_out = opnd_b - opnd_c;
      ALU_AND: alu_out = opnd_b & opnd_c;
      ALU_OR:  alu_out = opnd_b | opnd_c;
      ALU_XOR: alu_out = opnd_b ^ opnd_c;
      ALU_SHL: alu_out = opnd_b << opnd_c[4:0];
      ALU_SHR: alu_out = opnd_b >> opnd_c[4:0];
      default: alu_out = '0;
    endcase
  end

  always_comb
  begin
    case (ir_type)
      T_ALU:    result_next = alu_out;
      T_LDI:    result_next = imm;
      T_BRANCH: result_next = pc_i + imm;  // relative target
      T_JUMP:   result_next = imm;
      default:  result_next = '0;
    endcase
  end

  assign ccr_next.eq  = (opnd_b == opnd_c);
  assign ccr_next.lt  = ($signed(opnd_b) < $signed(opnd_c));
  assign ccr_next.ltu = (opnd_b < opnd_c);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      ex.ir        <= NOP_IR;
      ex.reg_write <= 1'b0;
      ex.ccr       <= '0;
    end
    else if (accept)
    begin
      ex.ir        <= ir_i[31:0];
      ex.reg_write <= (ir_type == T_ALU) || (ir_type == T_LDI);
      if (ir_type == T_CMP)
        ex.ccr <= ccr_next;
    end
    else if (!stall_i)
    begin
      ex.ir        <= NOP_IR;  // bubble, codes kept
      ex.reg_write <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      ex.pc     <= pc_i;
      ex.result <= result_next;
    end
  end

  a_known_type: assert property (
    @(posedge clk_i) disable iff (rst_i)
    accept |-> (ir_i[`TYPE_LSB +: 4] inside {T_NOP, T_ALU, T_CMP, T_LDI, T_BRANCH, T_JUMP})
  );

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`default_nettype none
`include "cpu_consts.svh"

module reg_file (
  input  wire               clk_i,
  input  wire               rst_i,
  input  wire [3:0]         ra_addr_i,
  input  wire [3:0]         rb_addr_i,
  output logic [`XLEN-1:0]  ra_data_o,
  output logic [`XLEN-1:0]  rb_data_o,
  input  wire               we_i,
  input  wire [3:0]         wr_addr_i,
  input  wire [`XLEN-1:0]   wr_data_i
);

  logic [`XLEN-1:0] regs [`NREGS];
  logic             hit_a;
  logic             hit_b;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < `NREGS; i++)
        regs[i] <= '0;
    end
    else if (we_i)
    begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // same-cycle write wins over stored value
  assign hit_a = we_i && (wr_addr_i == ra_addr_i);
  assign hit_b = we_i && (wr_addr_i == rb_addr_i);

  assign ra_data_o = hit_a ? wr_data_i : regs[ra_addr_i];
  assign rb_data_o = hit_b ? wr_data_i : regs[rb_addr_i];

  // bypass would leak X straight into execute
  a_wr_data_known: assert property (
    @(posedge clk_i) disable iff (rst_i)
    we_i |-> !$isunknown(wr_data_i)
  );

endmodule

`default_nettype wire

//--- rtl/exec_if.sv
`default_nettype none
`include "cpu_consts.svh"

interface exec_if;
  import cpu_pkg::*;

  logic [31:0]      ir;         // low instruction word
  logic [`XLEN-1:0] pc;
  ccr_t             ccr;        // codes in effect for this instr
  logic             reg_write;
  logic [`XLEN-1:0] result;     // alu value or target

  modport src (
    output ir,
    output pc,
    output ccr,
    output reg_write,
    output result
  );

  modport dst (
    input ir,
    input pc,
    input ccr,
    input reg_write,
    input result
  );

endinterface

`default_nettype wire

//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  typedef enum logic [3:0] {
    T_NOP    = 4'h0,  // bubble
    T_ALU    = 4'h1,
    T_CMP    = 4'h2,
    T_LDI    = 4'h3,
    T_BRANCH = 4'h4,
    T_JUMP   = 4'h5
  } ir_type_e;

  typedef enum logic [3:0] {
    ALU_ADD = 4'h0,
    ALU_SUB = 4'h1,
    ALU_AND = 4'h2,
    ALU_OR  = 4'h3,
    ALU_XOR = 4'h4,
    ALU_SHL = 4'h5,
    ALU_SHR = 4'h6   // logical
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_BRA  = 4'h0,
    BR_BEQ  = 4'h1,
    BR_BNE  = 4'h2,
    BR_BGTU = 4'h3,
    BR_BGT  = 4'h4,
    BR_BGE  = 4'h5,
    BR_BLE  = 4'h6,
    BR_BLT  = 4'h7,
    BR_BGEU = 4'h8,
    BR_BLTU = 4'h9,
    BR_BLEU = 4'ha
  } br_op_e;

  typedef struct packed {
    logic ltu;  // unsigned less
    logic lt;   // signed less
    logic eq;
  } ccr_t;

endpackage

`default_nettype wire

//--- rtl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath width, also the pc width
`define XLEN 32

// register file depth
`define NREGS 16

// 4-bit fields within the low instruction word
`define TYPE_LSB 28
`define OP_LSB 24
`define RA_LSB 20
`define RB_LSB 16
`define RC_LSB 12

`endif
